//--- src/lcd_cfg.svh
`ifndef LCD_CFG_SVH
`define LCD_CFG_SVH

// Last step of each phase, a phase lasts value + 1 cycles

// Wait before the first command
`define LCD_T_POWERUP 70

// Function set, entry mode and display on each
`define LCD_T_CMD 30

// Address command plus the characters of one line
`define LCD_T_LINE 20

// Return home needs the long settle time
`define LCD_T_HOME 400

`define LCD_T_CLEAR 200

// Step counter width, must hold LCD_T_HOME
`define LCD_STEP_W 9

// Columns written after the address command
`define LCD_MSG_COLS 9

`endif

//--- src/lcd_pkg.sv
package lcd_pkg;

    // Phases of the LCD write sequence
    typedef enum logic [2:0] {
        PH_POWERUP    = 3'd0,
        PH_FUNC_SET   = 3'd1,
        PH_ENTRY_MODE = 3'd2,
        PH_DISP_ON    = 3'd3,
        PH_LINE1      = 3'd4,
        PH_LINE2      = 3'd5,
        PH_HOME       = 3'd6,
        PH_CLEAR      = 3'd7
    } lcd_phase_e;

    // Result of the game, 11 shows as no winner
    typedef enum logic [1:0] {
        WIN_NONE = 2'b00,
        WIN_P1   = 2'b01,
        WIN_P2   = 2'b10
    } winner_e;

    // Set DDRAM address command
    typedef struct packed {
        logic       set_addr;              // Always 1 for this command
        logic [6:0] addr;
    } ddram_cmd_t;

    // One byte on the LCD data bus
    typedef union packed {
        logic [7:0] code;                  // Character or plain command
        ddram_cmd_t ddram;                 // Address command view
    } lcd_byte_u;

endpackage

//--- src/lcd_sequencer.sv
`include "lcd_cfg.svh"

module lcd_sequencer (
    input  logic                   clk,
    input  logic                   rst,
    output lcd_pkg::lcd_phase_e    phase,
    output logic [`LCD_STEP_W-1:0] step
);

    logic [`LCD_STEP_W-1:0] last_step;
    logic                   phase_done;
    lcd_pkg::lcd_phase_e    next_phase;

    // Duration of the current phase
    always_comb begin
        case (phase)
            lcd_pkg::PH_POWERUP: begin
                last_step = `LCD_STEP_W'(`LCD_T_POWERUP);
            end
            lcd_pkg::PH_FUNC_SET,
            lcd_pkg::PH_ENTRY_MODE,
            lcd_pkg::PH_DISP_ON: begin
                last_step = `LCD_STEP_W'(`LCD_T_CMD);
            end
            lcd_pkg::PH_LINE1,
            lcd_pkg::PH_LINE2: begin
                last_step = `LCD_STEP_W'(`LCD_T_LINE);
            end
            lcd_pkg::PH_HOME: begin
                last_step = `LCD_STEP_W'(`LCD_T_HOME);
            end
            lcd_pkg::PH_CLEAR: begin
                last_step = `LCD_STEP_W'(`LCD_T_CLEAR);
            end
            default: begin
                last_step = '0;
            end
        endcase
    end

    assign phase_done = (step == last_step);

    // Start-up runs once, then line1 .. clear loops
    always_comb begin
        case (phase)
            lcd_pkg::PH_POWERUP: begin
                next_phase = lcd_pkg::PH_FUNC_SET;
            end
            lcd_pkg::PH_FUNC_SET: begin
                next_phase = lcd_pkg::PH_ENTRY_MODE;
            end
            lcd_pkg::PH_ENTRY_MODE: begin
                next_phase = lcd_pkg::PH_DISP_ON;
            end
            lcd_pkg::PH_DISP_ON: begin
                next_phase = lcd_pkg::PH_LINE1;
            end
            lcd_pkg::PH_LINE1: begin
                next_phase = lcd_pkg::PH_LINE2;
            end
            lcd_pkg::PH_LINE2: begin
                next_phase = lcd_pkg::PH_HOME;
            end
            lcd_pkg::PH_HOME: begin
                next_phase = lcd_pkg::PH_CLEAR;
            end
            lcd_pkg::PH_CLEAR: begin
                next_phase = lcd_pkg::PH_LINE1;  // Back to the top of the loop
            end
            default: begin
                next_phase = lcd_pkg::PH_POWERUP;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            phase <= lcd_pkg::PH_POWERUP;
            step  <= '0;
        end else if (phase_done) begin
            phase <= next_phase;
            step  <= '0;
        end else begin
            step <= step + `LCD_STEP_W'(1);
        end
    end

endmodule

//--- src/lcd_text_rom.sv
`include "lcd_cfg.svh"

module lcd_text_rom (
    input  lcd_pkg::winner_e  winner,
    input  logic              line2,
    input  logic [4:0]        col,
    output lcd_pkg::lcd_byte_u char_byte
);

    localparam logic [7:0] CH_SPACE = 8'h20;
    localparam logic [7:0] CH_P     = 8'h50;
    localparam logic [7:0] CH_W     = 8'h57;
    localparam logic [7:0] CH_I     = 8'h69;
    localparam logic [7:0] CH_N     = 8'h6e;
    localparam logic [7:0] CH_ONE   = 8'h31;
    localparam logic [7:0] CH_TWO   = 8'h32;
    localparam logic [7:0] CH_HEART = 8'h9d;  // Heart glyph in the LCD font

    localparam logic [6:0] LINE1_ADDR = 7'h00;
    localparam logic [6:0] LINE2_ADDR = 7'h40;

    logic       has_winner;
    logic [7:0] digit;

    assign has_winner = (winner == lcd_pkg::WIN_P1) || (winner == lcd_pkg::WIN_P2);
    assign digit      = (winner == lcd_pkg::WIN_P2) ? CH_TWO : CH_ONE;

    always_comb begin
        char_byte.code = CH_SPACE;
        if (col == 5'd0) begin
            char_byte.ddram.set_addr = 1'b1;
            char_byte.ddram.addr     = line2 ? LINE2_ADDR : LINE1_ADDR;
        end else if (!has_winner || col > 5'(`LCD_MSG_COLS)) begin
            char_byte.code = CH_SPACE;  // Blank screen or padding
        end else if (!line2) begin
            // "P1 Win" / "P2 Win"
            case (col)
                5'd2: begin
                    char_byte.code = CH_P;
                end
                5'd3: begin
                    char_byte.code = digit;
                end
                5'd5: begin
                    char_byte.code = CH_W;
                end
                5'd6: begin
                    char_byte.code = CH_I;
                end
                5'd7: begin
                    char_byte.code = CH_N;
                end
                default: begin
                    char_byte.code = CH_SPACE;
                end
            endcase
        end else begin
            // Two groups of three hearts
            case (col)
                5'd2, 5'd3, 5'd4,
                5'd6, 5'd7, 5'd8: begin
                    char_byte.code = CH_HEART;
                end
                default: begin
                    char_byte.code = CH_SPACE;
                end
            endcase
        end
    end

endmodule

//--- src/lcd_bus_driver.sv
`include "lcd_cfg.svh"

module lcd_bus_driver (
    input  logic                   clk,
    input  logic                   rst,
    input  lcd_pkg::lcd_phase_e    phase,
    input  logic [`LCD_STEP_W-1:0] step,
    output logic                   line2,
    output logic [4:0]             col,
    input  lcd_pkg::lcd_byte_u     char_byte,
    output logic                   lcd_rs,
    output logic                   lcd_rw,
    output logic                   lcd_e,
    output logic [7:0]             lcd_data
);

    logic       rs_d;
    logic       rw_d;
    logic       e_d;
    logic [7:0] data_d;

    // Text position for the lookup, past the message stays on a blank column
    assign line2 = (phase == lcd_pkg::PH_LINE2);
    assign col   = (step > `LCD_STEP_W'(`LCD_MSG_COLS)) ? 5'(`LCD_MSG_COLS + 1)
                                                          : step[4:0];

    always_comb begin
        rs_d   = 1'b0;
        rw_d   = 1'b0;
        e_d    = 1'b1;  // High for every command or character
        data_d = 8'h00;
        case (phase)
            lcd_pkg::PH_POWERUP: begin
                rs_d   = 1'b1;
                rw_d   = 1'b1;
                e_d    = 1'b0;
            end
            lcd_pkg::PH_FUNC_SET: begin
                data_d = 8'h3c;  // 8-bit, 2 lines
            end
            lcd_pkg::PH_ENTRY_MODE: begin
                data_d = 8'h06;  // Increment, no shift
            end
            lcd_pkg::PH_DISP_ON: begin
                data_d = 8'h0c;  // Display on, cursor off
            end
            lcd_pkg::PH_LINE1,
            lcd_pkg::PH_LINE2: begin
                rs_d   = (step != '0);  // Step 0 is the address command
                data_d = char_byte.code;
            end
            lcd_pkg::PH_HOME: begin
                data_d = 8'h02;
            end
            lcd_pkg::PH_CLEAR: begin
                data_d = 8'h01;
            end
            default: begin
                e_d    = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            lcd_rs   <= 1'b0;
            lcd_rw   <= 1'b0;
            lcd_e    <= 1'b0;
            lcd_data <= 8'h00;
        end else begin
            lcd_rs   <= rs_d;
            lcd_rw   <= rw_d;
            lcd_e    <= e_d;
            lcd_data <= data_d;
        end
    end

endmodule

//--- src/lcd_result_top.sv
`include "lcd_cfg.svh"

module lcd_result_top (
    input  logic       clk,
    input  logic       rst,
    input  logic [1:0] winner,
    output logic       lcd_rs,
    output logic       lcd_rw,
    output logic       lcd_e,
    output logic [7:0] lcd_data
);

    lcd_pkg::lcd_phase_e    phase;
    logic [`LCD_STEP_W-1:0] step;
    logic                   line2;
    logic [4:0]             col;
    lcd_pkg::lcd_byte_u     char_byte;

    lcd_sequencer u_sequencer (
        .clk   (clk),
        .rst   (rst),
        .phase (phase),
        .step  (step)
    );

    // Code 11 passes through and reads as no winner
    lcd_text_rom u_text_rom (
        .winner    (lcd_pkg::winner_e'(winner)),
        .line2     (line2),
        .col       (col),
        .char_byte (char_byte)
    );

    lcd_bus_driver u_bus_driver (
        .clk       (clk),
        .rst       (rst),
        .phase     (phase),
        .step      (step),
        .line2     (line2),
        .col       (col),
        .char_byte (char_byte),
        .lcd_rs    (lcd_rs),
        .lcd_rw    (lcd_rw),
        .lcd_e     (lcd_e),
        .lcd_data  (lcd_data)
    );

endmodule

//--- verif/tb_lcd_model.svh
`ifndef TB_LCD_MODEL_SVH
`define TB_LCD_MODEL_SVH

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

function automatic int last_step_of(input lcd_pkg::lcd_phase_e ph);
    int last;
    case (ph)
        lcd_pkg::PH_POWERUP: last = `LCD_T_POWERUP;
        lcd_pkg::PH_LINE1, lcd_pkg::PH_LINE2: last = `LCD_T_LINE;
        lcd_pkg::PH_HOME: last = `LCD_T_HOME;
        lcd_pkg::PH_CLEAR: last = `LCD_T_CLEAR;
        default: last = `LCD_T_CMD;  // The three start-up commands
    endcase
    return last;
endfunction

function automatic lcd_pkg::lcd_phase_e next_phase_of(input lcd_pkg::lcd_phase_e ph);
    lcd_pkg::lcd_phase_e nxt;
    case (ph)
        lcd_pkg::PH_POWERUP: nxt = lcd_pkg::PH_FUNC_SET;
        lcd_pkg::PH_FUNC_SET: nxt = lcd_pkg::PH_ENTRY_MODE;
        lcd_pkg::PH_ENTRY_MODE: nxt = lcd_pkg::PH_DISP_ON;
        lcd_pkg::PH_DISP_ON: nxt = lcd_pkg::PH_LINE1;
        lcd_pkg::PH_LINE1: nxt = lcd_pkg::PH_LINE2;
        lcd_pkg::PH_LINE2: nxt = lcd_pkg::PH_HOME;
        lcd_pkg::PH_HOME: nxt = lcd_pkg::PH_CLEAR;
        default: nxt = lcd_pkg::PH_LINE1;
    endcase
    return nxt;
endfunction

// Screen text as it should look for a winner code
function automatic logic [7:0] expected_char(input logic [1:0] w, input logic line2,
                                             input int col);
    logic [7:0] ch;
    ch = 8'h20;
    if (col == 0) begin
        ch = line2 ? 8'hc0 : 8'h80;  // Set DDRAM address
    end else if ((w == 2'b01 || w == 2'b10) && col <= `LCD_MSG_COLS) begin
        if (!line2) begin
            case (col)
                2: ch = 8'h50;
                3: ch = (w == 2'b10) ? 8'h32 : 8'h31;
                5: ch = 8'h57;
                6: ch = 8'h69;
                7: ch = 8'h6e;
                default: ch = 8'h20;
            endcase
        end else if (col != 5 && col >= 2 && col <= 8) begin
            ch = 8'h9d;  // Heart
        end
    end
    return ch;
endfunction

task automatic predict_bus(input lcd_pkg::lcd_phase_e ph, input int stp, input logic [1:0] w,
                           output logic rs, output logic rw, output logic e,
                           output logic [7:0] data);
    rs = 1'b0;
    rw = 1'b0;
    e = 1'b1;
    data = 8'h00;
    case (ph)
        lcd_pkg::PH_POWERUP: begin
            rs = 1'b1;
            rw = 1'b1;
            e = 1'b0;
        end
        lcd_pkg::PH_FUNC_SET: data = 8'h3c;
        lcd_pkg::PH_ENTRY_MODE: data = 8'h06;
        lcd_pkg::PH_DISP_ON: data = 8'h0c;
        lcd_pkg::PH_HOME: data = 8'h02;
        lcd_pkg::PH_CLEAR: data = 8'h01;
        default: begin
            rs = (stp != 0);
            data = expected_char(w, ph == lcd_pkg::PH_LINE2, stp);
        end
    endcase
endtask

task automatic check_value(input string name, input logic [7:0] expected,
                           input logic [7:0] actual);
    if (actual !== expected) begin
        err_count++;
        $display("ERROR at %0t: %s expected %02h, got %02h", $time, name, expected, actual);
    end
endtask

`endif

//--- verif/tb_lcd_result.sv
`include "lcd_cfg.svh"

module tb_lcd_result;

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 8;
    localparam int STARTUP_CYCLES = (`LCD_T_POWERUP + 1) + 3 * (`LCD_T_CMD + 1);
    localparam int LOOP_CYCLES = 2 * (`LCD_T_LINE + 1) + (`LCD_T_HOME + 1) + (`LCD_T_CLEAR + 1);
    localparam int NUM_LOOPS = 6;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + STARTUP_CYCLES + NUM_LOOPS * LOOP_CYCLES + 100;

    logic       clk;
    logic       rst;
    logic [1:0] winner;
    logic       lcd_rs;
    logic       lcd_rw;
    logic       lcd_e;
    logic [7:0] lcd_data;

    int                  err_count;
    int                  test_pass;
    int                  test_fail;
    logic [31:0]         rng;
    int                  hold;
    lcd_pkg::lcd_phase_e m_phase;
    int                  m_step;
    logic                exp_rs;
    logic                exp_rw;
    logic                exp_e;
    logic [7:0]          exp_data;

`include "tb_lcd_model.svh"

    lcd_result_top UUT (
        .clk      (clk),
        .rst      (rst),
        .winner   (winner),
        .lcd_rs   (lcd_rs),
        .lcd_rw   (lcd_rw),
        .lcd_e    (lcd_e),
        .lcd_data (lcd_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // Model steps with the DUT on the winner set at the last falling edge
    always @(posedge clk) begin
        if (!rst) begin
            m_phase = lcd_pkg::PH_POWERUP;
            m_step = 0;
            exp_rs = 1'b0;
            exp_rw = 1'b0;
            exp_e = 1'b0;
            exp_data = 8'h00;
        end else begin
            predict_bus(m_phase, m_step, winner, exp_rs, exp_rw, exp_e, exp_data);
            if (m_step == last_step_of(m_phase)) begin
                m_phase = next_phase_of(m_phase);
                m_step = 0;
            end else begin
                m_step++;
            end
        end
    end

    // Check the pins, then drive the winner for the next cycle
    task automatic run_cycle(input logic [1:0] w);
        @(negedge clk);
        check_value("lcd_rs", {7'd0, exp_rs}, {7'd0, lcd_rs});
        check_value("lcd_rw", {7'd0, exp_rw}, {7'd0, lcd_rw});
        check_value("lcd_e", {7'd0, exp_e}, {7'd0, lcd_e});
        check_value("lcd_data", exp_data, lcd_data);
        winner = w;
    endtask

    task automatic run_random(input int cycles);
        repeat (cycles) begin
            if (hold == 0) begin
                rng = xorshift32(rng);
                hold = 1 + int'(rng % 32'd1000);
                rng = xorshift32(rng);
                winner = rng[1:0];  // Code 11 included
            end
            hold = hold - 1;
            run_cycle(winner);
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            test_pass++;
            $display("Test %s: passed", name);
        end else begin
            test_fail++;
            $display("Test %s: failed with %0d mismatches", name, err_count - errs_before);
        end
    endtask

    initial begin
        int errs;
        rst = 1'b0;
        winner = 2'b00;
        err_count = 0;
        test_pass = 0;
        test_fail = 0;
        rng = 32'd54411;
        hold = 0;

        errs = err_count;
        repeat (RESET_CYCLES) run_cycle(2'b00);
        rst = 1'b1;
        repeat (`LCD_T_POWERUP + 1) run_cycle(2'b00);
        finish_test("reset and power-up wait", errs);

        errs = err_count;
        repeat (3 * (`LCD_T_CMD + 1)) run_cycle(2'b00);
        finish_test("start-up commands", errs);

        // Each loop test covers exactly one line1 .. clear pass
        errs = err_count;
        repeat (LOOP_CYCLES) run_cycle(lcd_pkg::WIN_P1);
        finish_test("player 1 result", errs);

        errs = err_count;
        repeat (LOOP_CYCLES) run_cycle(lcd_pkg::WIN_P2);
        finish_test("player 2 result", errs);

        errs = err_count;
        repeat (LOOP_CYCLES) run_cycle(lcd_pkg::WIN_NONE);
        finish_test("no winner", errs);

        errs = err_count;
        repeat (LOOP_CYCLES) run_cycle(2'b11);
        finish_test("code 11 shown as no winner", errs);

        // Winner flips on the digit of line 1 and on the third heart of line 2
        errs = err_count;
        repeat (2) run_cycle(lcd_pkg::WIN_P1);
        repeat (22) run_cycle(lcd_pkg::WIN_P2);
        repeat (18) run_cycle(lcd_pkg::WIN_NONE);
        finish_test("winner change mid-line", errs);

        errs = err_count;
        run_random((NUM_LOOPS - 4) * LOOP_CYCLES - 2 * (`LCD_T_LINE + 1));
        finish_test("random winner changes", errs);

        $display("Tests passed: %0d, failed: %0d, mismatches: %0d",
                 test_pass, test_fail, err_count);
        if (test_fail == 0 && err_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+src
+incdir+verif
src/lcd_pkg.sv
src/lcd_sequencer.sv
src/lcd_text_rom.sv
src/lcd_bus_driver.sv
src/lcd_result_top.sv
verif/tb_lcd_result.sv

//--- run.sh
#!/bin/sh
# Build and run the LCD result testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_lcd_result

verilator --binary --timing -j 0 -f src.f --top-module tb_lcd_result -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator compile failed with status $status"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
    echo "Result: pass"
    exit 0
else
    echo "Result: fail, see $LOG"
    exit 1
fi
